// File: src/int_backend_defines.svh
`ifndef INT_BACKEND_DEFINES_SVH
`define INT_BACKEND_DEFINES_SVH

// integer back end sizing

// number of slots in the integer issue queue
`define IQ_N_ENTRIES 8

// reorder buffer tag width, 32 in-flight ops
`define ROB_ID_WIDTH 5

// register data width
`define XLEN 32

`endif

// File: src/result_bus_pkg.sv
`default_nettype none

`include "int_backend_defines.svh"

package result_bus_pkg;

    typedef logic [`ROB_ID_WIDTH-1:0] rob_id_t;
    typedef logic [`XLEN-1:0]         reg_data_t;

    // one result on the ALU or load broadcast
    typedef struct packed {
        logic      valid;
        rob_id_t   rob_id;
        reg_data_t data;
    } broadcast_t;

    typedef struct packed {
        logic      valid;
        rob_id_t   rob_id;
        reg_data_t data;      // rd value, pc+4 for jumps
        logic      br_taken;  // jumps are always taken
        reg_data_t br_target; // computed target of a branch or jump
    } completion_t;

endpackage

`default_nettype wire

// File: src/int_uop_pkg.sv
`default_nettype none

package int_uop_pkg;

    // decoded integer operation
    typedef struct packed {
        logic [2:0]                funct3; // alu op or branch condition
        result_bus_pkg::reg_data_t imm;    // sign extended, u-type already shifted up
        result_bus_pkg::reg_data_t pc;
        logic                      is_r_type;
        logic                      is_i_type;
        logic                      is_u_type;   // lui and auipc
        logic                      is_b_type;
        logic                      is_j_type;   // jal
        logic                      is_sub;      // r-type only
        logic                      is_sra_srai;
        logic                      is_lui;      // else auipc
        logic                      is_jalr;
    } int_uop_t;

    // one source operand as tracked in the queue
    typedef struct packed {
        logic                      used;
        result_bus_pkg::rob_id_t   rob_id; // producer tag
        logic                      ready;
        result_bus_pkg::reg_data_t data;
    } iq_src_t;

    typedef struct packed {
        iq_src_t                 src1;
        iq_src_t                 src2;
        logic                    dst_valid;
        result_bus_pkg::rob_id_t instr_rob_id;
        int_uop_t                uop;
    } iq_entry_t;

    // contents of the issue buffer
    typedef struct packed {
        logic                      valid;
        result_bus_pkg::rob_id_t   instr_rob_id;
        logic                      dst_valid;
        result_bus_pkg::reg_data_t src1_data; // after bypass
        result_bus_pkg::reg_data_t src2_data;
        int_uop_t                  uop;
    } issue_data_t;

endpackage

`default_nettype wire

// File: src/issue_shift_queue.sv
`timescale 1ns/1ns
`default_nettype none

`include "int_backend_defines.svh"

module issue_shift_queue #(
    parameter int N_ENTRIES = `IQ_N_ENTRIES
) (
    input  logic                                   clk,
    input  logic                                   arst_n,
    input  logic                                   flush,
    input  logic                                   enq_valid,
    output logic                                   enq_ready,
    input  int_uop_pkg::iq_entry_t                 enq_entry,
    input  logic [N_ENTRIES-1:0]                   deq_sel_onehot,
    input  logic [N_ENTRIES-1:0]                   wr_en,
    input  int_uop_pkg::iq_entry_t [N_ENTRIES-1:0] wr_entries,
    output int_uop_pkg::iq_entry_t [N_ENTRIES-1:0] entries,
    output logic [N_ENTRIES-1:0]                   entries_valid
);
    import int_uop_pkg::*;

    localparam int CNT_W = $clog2(N_ENTRIES + 1);
    localparam int IDX_W = $clog2(N_ENTRIES);

    logic [CNT_W-1:0]          count_q;  // occupied slots, all at the bottom
    iq_entry_t [N_ENTRIES:0]   updated;  // one spare empty slot past the top
    iq_entry_t [N_ENTRIES-1:0] entries_d;
    logic [N_ENTRIES-1:0]      deq_hit;
    logic                      deq_fire;
    logic                      enq_fire;
    logic [CNT_W-1:0]          tail;

    always_comb begin
        for (int i = 0; i < N_ENTRIES; i++) begin
            entries_valid[i] = CNT_W'(i) < count_q;
        end
    end

    assign enq_ready = count_q != CNT_W'(N_ENTRIES);
    assign enq_fire  = enq_valid && enq_ready;
    assign deq_hit   = deq_sel_onehot & entries_valid;
    assign deq_fire  = |deq_hit;
    assign tail      = count_q - CNT_W'(deq_fire); // first free slot after the collapse

    // wakeup and capture rewrites land before the shift
    always_comb begin
        updated = '0;
        for (int i = 0; i < N_ENTRIES; i++) begin
            updated[i] = wr_en[i] ? wr_entries[i] : entries[i];
        end
    end

    always_comb begin
        logic shifting;
        shifting = 1'b0;
        for (int i = 0; i < N_ENTRIES; i++) begin
            shifting     = shifting | deq_hit[i];
            entries_d[i] = shifting ? updated[i+1] : updated[i]; // younger ones move down
        end
        if (enq_fire) begin
            entries_d[tail[IDX_W-1:0]] = enq_entry;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count_q <= '0;
        end else if (flush) begin
            count_q <= '0;
        end else begin
            count_q <= count_q + CNT_W'(enq_fire) - CNT_W'(deq_fire);
        end
    end

    // slot contents only matter below count_q
    always_ff @(posedge clk) begin
        entries <= entries_d;
    end

endmodule

`default_nettype wire

// File: src/integer_issue.sv
`timescale 1ns/1ns
`default_nettype none

`include "int_backend_defines.svh"

module integer_issue (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       flush,
    input  logic                       dispatch_valid,
    output logic                       dispatch_ready,
    input  int_uop_pkg::iq_entry_t     dispatch_entry,
    input  result_bus_pkg::broadcast_t alu_bcast,
    input  result_bus_pkg::broadcast_t ld_bcast,
    output int_uop_pkg::issue_data_t   issue_data
);
    import result_bus_pkg::*;
    import int_uop_pkg::*;

    localparam int N = `IQ_N_ENTRIES;

    iq_entry_t [N-1:0] entries;
    logic [N-1:0]      entries_valid;
    logic [N-1:0]      entries_ready;
    logic [N-1:0]      sel_onehot;
    iq_entry_t         sel_entry;
    logic              issue_valid;
    logic              wake_valid;
    logic [N-1:0]      wr_en;
    iq_entry_t [N-1:0] wr_entries;
    iq_entry_t         enq_entry;
    issue_data_t       buffer_d;
    issue_data_t       buffer_q;
    logic              buffer_valid_q;

    // a matching alu broadcast is taken even by a source that was never woken,
    // which covers an op dispatched in the same cycle as its producer's broadcast
    function automatic iq_src_t update_src(input iq_src_t src, input logic wake,
                                           input rob_id_t wake_tag,
                                           input broadcast_t alu, input broadcast_t ld);
        iq_src_t res;
        res = src;
        if (src.used) begin
            if (wake && src.rob_id == wake_tag) begin
                res.ready = 1'b1; // data follows on alu_bcast next cycle
            end
            if (alu.valid && src.rob_id == alu.rob_id) begin
                res.ready = 1'b1;
                res.data  = alu.data;
            end else if (!src.ready && ld.valid && src.rob_id == ld.rob_id) begin
                res.ready = 1'b1;
                res.data  = ld.data;
            end
        end
        return res;
    endfunction

    function automatic reg_data_t bypass(input iq_src_t src, input broadcast_t alu,
                                         input broadcast_t ld);
        if (src.used && alu.valid && alu.rob_id == src.rob_id) begin
            return alu.data;
        end
        if (src.used && ld.valid && ld.rob_id == src.rob_id) begin
            return ld.data;
        end
        return src.data;
    endfunction

    issue_shift_queue #(
        .N_ENTRIES(N)
    ) u_queue (
        .clk(clk),
        .arst_n(arst_n),
        .flush(flush),
        .enq_valid(dispatch_valid),
        .enq_ready(dispatch_ready),
        .enq_entry(enq_entry),
        .deq_sel_onehot(sel_onehot),
        .wr_en(wr_en),
        .wr_entries(wr_entries),
        .entries(entries),
        .entries_valid(entries_valid)
    );

    // oldest ready entry wins, lowest index is oldest
    always_comb begin
        logic found;
        found      = 1'b0;
        sel_onehot = '0;
        sel_entry  = '0;
        for (int i = 0; i < N; i++) begin
            entries_ready[i] = entries_valid[i] &&
                               (!entries[i].src1.used || entries[i].src1.ready) &&
                               (!entries[i].src2.used || entries[i].src2.ready);
            if (entries_ready[i] && !found) begin
                sel_onehot[i] = 1'b1;
                sel_entry     = entries[i];
                found         = 1'b1;
            end
        end
    end

    assign issue_valid = |entries_ready;
    assign wake_valid  = issue_valid && sel_entry.dst_valid; // only producers wake anyone

    always_comb begin
        for (int i = 0; i < N; i++) begin
            wr_entries[i]      = entries[i];
            wr_entries[i].src1 = update_src(entries[i].src1, wake_valid,
                                            sel_entry.instr_rob_id, alu_bcast, ld_bcast);
            wr_entries[i].src2 = update_src(entries[i].src2, wake_valid,
                                            sel_entry.instr_rob_id, alu_bcast, ld_bcast);
            wr_en[i]           = entries_valid[i] && (wr_entries[i] != entries[i]);
        end
    end

    // same wakeup and capture for the op entering this cycle
    always_comb begin
        enq_entry      = dispatch_entry;
        enq_entry.src1 = update_src(dispatch_entry.src1, wake_valid,
                                    sel_entry.instr_rob_id, alu_bcast, ld_bcast);
        enq_entry.src2 = update_src(dispatch_entry.src2, wake_valid,
                                    sel_entry.instr_rob_id, alu_bcast, ld_bcast);
    end

    assign buffer_d = '{
        valid:        issue_valid,
        instr_rob_id: sel_entry.instr_rob_id,
        dst_valid:    sel_entry.dst_valid,
        src1_data:    bypass(sel_entry.src1, alu_bcast, ld_bcast),
        src2_data:    bypass(sel_entry.src2, alu_bcast, ld_bcast),
        uop:          sel_entry.uop
    };

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            buffer_valid_q <= 1'b0;
        end else if (flush) begin
            buffer_valid_q <= 1'b0;
        end else begin
            buffer_valid_q <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        buffer_q <= buffer_d;
    end

    always_comb begin
        issue_data       = buffer_q;
        issue_data.valid = buffer_valid_q;
    end

endmodule

`default_nettype wire

// File: src/integer_alu.sv
`timescale 1ns/1ns
`default_nettype none

`include "int_backend_defines.svh"

module integer_alu (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        flush,
    input  int_uop_pkg::issue_data_t    issue_data,
    output result_bus_pkg::broadcast_t  alu_bcast,
    output result_bus_pkg::completion_t completion
);
    import result_bus_pkg::*;
    import int_uop_pkg::*;

    localparam int SHAMT_W = $clog2(`XLEN);

    int_uop_t           uop;
    reg_data_t          op_a;
    reg_data_t          op_b;
    logic [SHAMT_W-1:0] shamt;
    reg_data_t          pc_plus4;
    reg_data_t          result;
    logic               br_taken;
    reg_data_t          br_target;
    completion_t        comp_d;
    completion_t        comp_q;
    logic               comp_valid_q;

    assign uop      = issue_data.uop;
    assign op_a     = issue_data.src1_data;
    assign op_b     = uop.is_r_type ? issue_data.src2_data : uop.imm;
    assign shamt    = op_b[SHAMT_W-1:0];
    assign pc_plus4 = uop.pc + reg_data_t'(4);

    always_comb begin
        result    = '0;
        br_taken  = 1'b0;
        br_target = '0;
        if (uop.is_u_type) begin
            result = uop.is_lui ? uop.imm : uop.pc + uop.imm;
        end else if (uop.is_j_type) begin
            result    = pc_plus4;
            br_taken  = 1'b1;
            br_target = uop.pc + uop.imm;
        end else if (uop.is_i_type && uop.is_jalr) begin
            result    = pc_plus4;
            br_taken  = 1'b1;
            br_target = (op_a + uop.imm) & ~reg_data_t'(1); // lsb dropped
        end else if (uop.is_b_type) begin
            br_target = uop.pc + uop.imm; // reported whether taken or not
            case (uop.funct3)
                3'b000:  br_taken = op_a == issue_data.src2_data;
                3'b001:  br_taken = op_a != issue_data.src2_data;
                3'b100:  br_taken = $signed(op_a) < $signed(issue_data.src2_data);
                3'b101:  br_taken = $signed(op_a) >= $signed(issue_data.src2_data);
                3'b110:  br_taken = op_a < issue_data.src2_data;
                3'b111:  br_taken = op_a >= issue_data.src2_data;
                default: br_taken = 1'b0;
            endcase
        end else begin
            case (uop.funct3)
                3'b000:  result = (uop.is_r_type && uop.is_sub) ? op_a - op_b : op_a + op_b;
                3'b001:  result = op_a << shamt;
                3'b010:  result = reg_data_t'($signed(op_a) < $signed(op_b));
                3'b011:  result = reg_data_t'(op_a < op_b);
                3'b100:  result = op_a ^ op_b;
                3'b101:  result = uop.is_sra_srai ? reg_data_t'($signed(op_a) >>> shamt)
                                                  : op_a >> shamt;
                3'b110:  result = op_a | op_b;
                default: result = op_a & op_b;
            endcase
        end
    end

    // branches have no destination so they stay off the bus
    assign alu_bcast = '{
        valid:  issue_data.valid && issue_data.dst_valid,
        rob_id: issue_data.instr_rob_id,
        data:   result
    };

    assign comp_d = '{
        valid:     issue_data.valid,
        rob_id:    issue_data.instr_rob_id,
        data:      result,
        br_taken:  br_taken,
        br_target: br_target
    };

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            comp_valid_q <= 1'b0;
        end else if (flush) begin
            comp_valid_q <= 1'b0;
        end else begin
            comp_valid_q <= issue_data.valid;
        end
    end

    always_ff @(posedge clk) begin
        comp_q <= comp_d;
    end

    always_comb begin
        completion       = comp_q;
        completion.valid = comp_valid_q;
    end

endmodule

`default_nettype wire

// File: src/int_backend_top.sv
`timescale 1ns/1ns
`default_nettype none

module int_backend_top (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        dispatch_valid,
    output logic                        dispatch_ready,
    input  int_uop_pkg::iq_entry_t      dispatch_entry,
    input  result_bus_pkg::broadcast_t  ld_bcast,
    input  logic                        fetch_redirect_valid,
    output result_bus_pkg::completion_t completion
);
    import result_bus_pkg::*;
    import int_uop_pkg::*;

    broadcast_t  alu_bcast;  // loops back for wakeup capture and bypass
    issue_data_t issue_data;

    integer_issue u_issue (
        .clk(clk),
        .arst_n(arst_n),
        .flush(fetch_redirect_valid),
        .dispatch_valid(dispatch_valid),
        .dispatch_ready(dispatch_ready),
        .dispatch_entry(dispatch_entry),
        .alu_bcast(alu_bcast),
        .ld_bcast(ld_bcast),
        .issue_data(issue_data)
    );

    integer_alu u_alu (
        .clk(clk),
        .arst_n(arst_n),
        .flush(fetch_redirect_valid), // redirect clears every stage
        .issue_data(issue_data),
        .alu_bcast(alu_bcast),
        .completion(completion)
    );

endmodule

`default_nettype wire

// File: testbench/tb_int_backend.sv
`timescale 1ns/1ns
`default_nettype none

module tb_int_backend;
    import result_bus_pkg::*;
    import int_uop_pkg::*;

    typedef enum int {
        K_ADD, K_SUB, K_SLL, K_SLT, K_XOR, K_SRA, K_OR, K_AND, K_ADDI,
        K_LUI, K_AUIPC, K_BEQ, K_BNE, K_BLT, K_BGEU, K_JAL, K_JALR
    } kind_t;

    // source modes are unused, ready, previous row, load and copy of src1
    typedef enum int {M_NONE, M_RDY, M_PREV, M_LOAD, M_SAME} mode_t;

    typedef struct {
        kind_t     kind;
        mode_t     m1;
        mode_t     m2;
        reg_data_t imm;
    } row_t;

    localparam int      N_ROWS  = 22;
    localparam rob_id_t RDY_TAG = 5'd30; // never used as a rob id

    logic        clk;
    logic        arst_n;
    logic        dispatch_valid;
    logic        dispatch_ready;
    iq_entry_t   dispatch_entry;
    broadcast_t  ld_bcast;
    logic        fetch_redirect_valid;
    completion_t completion;

    row_t      rows [N_ROWS];
    rob_id_t   ld_tag;
    reg_data_t ld_data;
    reg_data_t exp_res [32];
    bit        exp_taken [32];
    reg_data_t exp_tgt [32];
    bit        done [32];
    reg_data_t got_res [32];
    bit        got_taken [32];
    reg_data_t got_tgt [32];
    int        got_cyc [32];
    int        cyc;

    int_backend_top u_dut (
        .clk(clk),
        .arst_n(arst_n),
        .dispatch_valid(dispatch_valid),
        .dispatch_ready(dispatch_ready),
        .dispatch_entry(dispatch_entry),
        .ld_bcast(ld_bcast),
        .fetch_redirect_valid(fetch_redirect_valid),
        .completion(completion)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // completion is sampled with its pre-edge value
    always @(posedge clk) begin
        if (arst_n && completion.valid) begin
            done[completion.rob_id]      = 1'b1;
            got_res[completion.rob_id]   = completion.data;
            got_taken[completion.rob_id] = completion.br_taken;
            got_tgt[completion.rob_id]   = completion.br_target;
            got_cyc[completion.rob_id]   = cyc;
        end
        cyc++;
    end

    task automatic stop_failed();
        $display("Result: FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic fail_now(input string msg);
        $display("%s", msg);
        stop_failed();
    endtask

    task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("error at %0t ns: %s got %h expected %h", $time, what, got, exp);
            stop_failed();
        end
    endtask

    function automatic int_uop_t make_uop(input kind_t kind, input reg_data_t imm,
                                          input reg_data_t pc);
        int_uop_t u;
        u             = '0;
        u.imm         = imm;
        u.pc          = pc;
        u.is_r_type   = kind <= K_AND;
        u.is_i_type   = kind == K_ADDI || kind == K_JALR;
        u.is_u_type   = kind == K_LUI || kind == K_AUIPC;
        u.is_b_type   = kind >= K_BEQ && kind <= K_BGEU;
        u.is_j_type   = kind == K_JAL;
        u.is_sub      = kind == K_SUB;
        u.is_sra_srai = kind == K_SRA;
        u.is_lui      = kind == K_LUI;
        u.is_jalr     = kind == K_JALR;
        case (kind)
            K_SLL, K_BNE:  u.funct3 = 3'b001;
            K_SLT:         u.funct3 = 3'b010;
            K_XOR, K_BLT:  u.funct3 = 3'b100;
            K_SRA:         u.funct3 = 3'b101;
            K_OR:          u.funct3 = 3'b110;
            K_AND, K_BGEU: u.funct3 = 3'b111;
            default:       u.funct3 = 3'b000;
        endcase
        return u;
    endfunction

    // rv32i semantics
    task automatic ref_exec(input kind_t kind, input reg_data_t a, input reg_data_t b,
                            input reg_data_t imm, input reg_data_t pc, output reg_data_t res,
                            output bit taken, output reg_data_t tgt);
        res   = '0;
        taken = 1'b0;
        tgt   = '0;
        case (kind)
            K_ADD:         res = a + b;
            K_SUB:         res = a - b;
            K_SLL:         res = a << b[4:0];
            K_SLT:         res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            K_XOR:         res = a ^ b;
            K_SRA:         res = $signed(a) >>> b[4:0];
            K_OR:          res = a | b;
            K_AND:         res = a & b;
            K_ADDI:        res = a + imm;
            K_LUI:         res = imm;
            K_AUIPC:       res = pc + imm;
            K_JAL, K_JALR: res = pc + 32'd4; // link value
            default:       ;
        endcase
        case (kind)
            K_BEQ:         taken = a == b;
            K_BNE:         taken = a != b;
            K_BLT:         taken = $signed(a) < $signed(b);
            K_BGEU:        taken = a >= b;
            K_JAL, K_JALR: taken = 1'b1;
            default:       ;
        endcase
        if (kind >= K_BEQ) begin
            tgt = (kind == K_JALR) ? (a + imm) & ~32'h1 : pc + imm;
        end
    endtask

    task automatic pick_src(input mode_t m, input int rob, input reg_data_t other,
                            output iq_src_t s, output reg_data_t v);
        s = '0;
        v = '0;
        case (m)
            M_RDY, M_SAME: begin
                v = (m == M_SAME) ? other : $urandom;
                s = '{used: 1'b1, rob_id: RDY_TAG, ready: 1'b1, data: v};
            end
            M_PREV: begin
                v = exp_res[rob-1];
                s = '{used: 1'b1, rob_id: rob_id_t'(rob - 1), ready: 1'b0, data: 32'hdead_beef};
            end
            M_LOAD: begin
                v = ld_data;
                s = '{used: 1'b1, rob_id: ld_tag, ready: 1'b0, data: 32'hdead_beef};
            end
            default: ;
        endcase
    endtask

    // starts and ends on a falling edge
    task automatic dispatch(input iq_entry_t e);
        int n;
        n = 0;
        dispatch_valid = 1'b1;
        dispatch_entry = e;
        while (!dispatch_ready) begin
            @(negedge clk);
            n++;
            if (n > 100) fail_now("timeout: dispatch_ready stayed low");
        end
        @(negedge clk);
        dispatch_valid = 1'b0;
    endtask

    task automatic send_op(input kind_t kind, input int rob, input mode_t m1, input mode_t m2,
                           input reg_data_t imm);
        iq_entry_t e;
        reg_data_t a;
        reg_data_t b;
        reg_data_t pc;
        pc = $urandom & ~32'h3;
        pick_src(m1, rob, '0, e.src1, a);
        pick_src(m2, rob, a, e.src2, b);
        e.dst_valid    = kind < K_BEQ || kind > K_BGEU; // branches write nothing
        e.instr_rob_id = rob_id_t'(rob);
        e.uop          = make_uop(kind, imm, pc);
        ref_exec(kind, a, b, imm, pc, exp_res[rob], exp_taken[rob], exp_tgt[rob]);
        dispatch(e);
    endtask

    task automatic pulse_load(input rob_id_t tag, input reg_data_t data);
        ld_bcast = '{valid: 1'b1, rob_id: tag, data: data};
        @(negedge clk);
        ld_bcast = '0;
    endtask

    task automatic clear_done();
        for (int i = 0; i < 32; i++) begin
            done[i] = 1'b0;
        end
    endtask

    task automatic wait_done(input int lo, input int hi);
        int n;
        bit all;
        n   = 0;
        all = 1'b0;
        while (!all) begin
            all = 1'b1;
            for (int i = lo; i <= hi; i++) begin
                all &= done[i];
            end
            if (!all) begin
                @(negedge clk);
                n++;
                if (n > 200) fail_now($sformatf("timeout: rob ids %0d to %0d not all completed",
                                                lo, hi));
            end
        end
    endtask

    task automatic check_rows(input int lo, input int hi);
        for (int i = lo; i <= hi; i++) begin
            check_val(got_res[i], exp_res[i], $sformatf("rob %0d result", i));
            check_val(32'(got_taken[i]), 32'(exp_taken[i]), $sformatf("rob %0d taken", i));
            check_val(got_tgt[i], exp_tgt[i], $sformatf("rob %0d target", i));
        end
    endtask

    task automatic fill_table();
        rows[0]  = '{K_ADD,   M_RDY,  M_RDY,  32'h0};
        rows[1]  = '{K_SUB,   M_RDY,  M_RDY,  32'h0};
        rows[2]  = '{K_SLL,   M_RDY,  M_RDY,  32'h0};
        rows[3]  = '{K_SLT,   M_RDY,  M_RDY,  32'h0};
        rows[4]  = '{K_XOR,   M_RDY,  M_RDY,  32'h0};
        rows[5]  = '{K_SRA,   M_RDY,  M_RDY,  32'h0};
        rows[6]  = '{K_OR,    M_RDY,  M_RDY,  32'h0};
        rows[7]  = '{K_AND,   M_RDY,  M_RDY,  32'h0};
        rows[8]  = '{K_ADDI,  M_RDY,  M_NONE, 32'hffff_fffb};
        rows[9]  = '{K_LUI,   M_NONE, M_NONE, 32'h1234_5000};
        rows[10] = '{K_AUIPC, M_NONE, M_NONE, 32'h0001_0000};
        rows[11] = '{K_ADDI,  M_RDY,  M_NONE, 32'd100};     // chain head
        rows[12] = '{K_ADD,   M_PREV, M_RDY,  32'h0};
        rows[13] = '{K_XOR,   M_PREV, M_RDY,  32'h0};
        rows[14] = '{K_ADD,   M_PREV, M_PREV, 32'h0};
        rows[15] = '{K_ADD,   M_LOAD, M_RDY,  32'h0};       // held until the load pulse
        rows[16] = '{K_BEQ,   M_RDY,  M_SAME, 32'hffff_fff0};
        rows[17] = '{K_BNE,   M_RDY,  M_RDY,  32'h0000_0100};
        rows[18] = '{K_BLT,   M_RDY,  M_RDY,  32'h0000_0040};
        rows[19] = '{K_BGEU,  M_RDY,  M_RDY,  32'hffff_ff80};
        rows[20] = '{K_JAL,   M_NONE, M_NONE, 32'h0000_0800};
        rows[21] = '{K_JALR,  M_RDY,  M_NONE, 32'h0000_0013};
    endtask

    initial begin
        void'($urandom(32'he52a_5fc7));
        arst_n               = 1'b0;
        dispatch_valid       = 1'b0;
        dispatch_entry       = '0;
        ld_bcast             = '0;
        fetch_redirect_valid = 1'b0;
        ld_tag               = 5'd31;
        ld_data              = $urandom;
        clear_done();
        fill_table();
        repeat (10) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        check_val(32'(dispatch_ready), 32'd1, "dispatch_ready after reset");

        // independent ops, chain, load wait, branches and jumps
        for (int i = 0; i < N_ROWS; i++) begin
            if (rows[i].m1 != M_PREV && rows[i].m2 != M_PREV) begin
                repeat ($urandom % 3) @(negedge clk); // consumers must follow at once
            end
            send_op(rows[i].kind, i, rows[i].m1, rows[i].m2, rows[i].imm);
            if (rows[i].m1 == M_LOAD) begin
                repeat (6) @(negedge clk);
                check_val(32'(done[i]), 32'd0, "op completed before its load data");
                pulse_load(ld_tag, ld_data);
            end
        end
        wait_done(0, N_ROWS - 1);
        check_rows(0, N_ROWS - 1);

        // the chain issues back to back through wakeup and bypass
        for (int i = 12; i <= 14; i++) begin
            check_val(32'(got_cyc[i]), 32'(got_cyc[i-1] + 1),
                      $sformatf("rob %0d completion cycle", i));
        end

        // fill the queue behind an unsent load
        clear_done();
        ld_tag  = 5'd29;
        ld_data = $urandom;
        for (int i = 0; i < 8; i++) begin
            send_op(K_ADDI, i, M_LOAD, M_NONE, reg_data_t'(i * 3));
        end
        check_val(32'(dispatch_ready), 32'd0, "dispatch_ready with a full queue");
        repeat (4) @(negedge clk);
        check_val(32'(dispatch_ready), 32'd0, "dispatch_ready while stalled");
        pulse_load(ld_tag, ld_data);
        ld_tag  = 5'd28;
        ld_data = $urandom;
        send_op(K_ADDI, 8, M_LOAD, M_NONE, 32'd77); // ninth op enters once a slot frees
        pulse_load(ld_tag, ld_data);
        wait_done(0, 8);
        check_rows(0, 8);

        // redirect drops a full queue
        clear_done();
        ld_tag  = 5'd27;
        ld_data = $urandom;
        for (int i = 10; i < 18; i++) begin
            send_op(K_ADD, i, M_LOAD, M_RDY, '0);
        end
        check_val(32'(dispatch_ready), 32'd0, "dispatch_ready before redirect");
        fetch_redirect_valid = 1'b1;
        @(negedge clk);
        fetch_redirect_valid = 1'b0;
        check_val(32'(dispatch_ready), 32'd1, "dispatch_ready after redirect");
        pulse_load(ld_tag, ld_data);
        repeat (10) @(negedge clk);
        for (int i = 10; i < 18; i++) begin
            check_val(32'(done[i]), 32'd0, $sformatf("flushed rob %0d completed", i));
        end
        send_op(K_SUB, 18, M_RDY, M_RDY, '0);
        send_op(K_OR, 19, M_RDY, M_RDY, '0);
        wait_done(18, 19);
        check_rows(18, 19);

        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+src
src/result_bus_pkg.sv
src/int_uop_pkg.sv
src/issue_shift_queue.sv
src/integer_issue.sv
src/integer_alu.sv
src/int_backend_top.sv
testbench/tb_int_backend.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the integer back end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f build.f --top-module tb_int_backend -o tb_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

out=$(./obj_dir/tb_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Result: PASSED"; then
    exit 0
fi
echo "pass message not found"
exit 1
